//--- sim.f
common/ring_pkg.sv
ring/inject_fifo.sv
ring/ring_stop.sv
ring/ring_node.sv
verilog/ring_bus_top.sv
+incdir+verification
verification/ring_bus_tb.sv

//--- verification/ring_bus_scoreboard.svh
`ifndef RING_BUS_SCOREBOARD_SVH
`define RING_BUS_SCOREBOARD_SVH

// ------------------------------------------------------------
// expected flits, one queue per destination stop
// ------------------------------------------------------------

// flits in injection order, plus the cycle each one is due
ring_flit_t exp_q [NODE_COUNT][$];
int         due_q [NODE_COUNT][$];

// flits accepted but not yet ejected
int outstanding = 0;

// xorshift state, seed 66
logic [31:0] rng_state = 32'd66;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

task automatic next_rand(output logic [31:0] r);
	rng_state = xorshift32(rng_state);
	r = rng_state;
endtask

// hops between insertion and arrival, a self-addressed flit makes a full lap
function automatic int hop_count(input int s, input int d);
	return (d - s - 1 + NODE_COUNT) % NODE_COUNT;
endfunction

// record a flit accepted at enabled cycle acc_cyc
task automatic expect_flit(input ring_flit_t f, input int acc_cyc);
	exp_q[f.dst].push_back(f);
	// one cycle into the queue, one into the slot, then the hops
	due_q[f.dst].push_back(acc_cyc + hop_count(f.src, f.dst) + 2);
	outstanding++;
endtask

// match an ejected flit against the front, or against any entry
task automatic take_flit(input int d, input ring_flit_t f, input bit in_order,
		output bit found, output bit have_exp, output ring_flit_t front, output int due);
	int i;
	found    = 1'b0;
	have_exp = 1'b0;
	front    = '0;
	due      = -1;
	if (exp_q[d].size() == 0) begin
		return;
	end
	if (in_order) begin
		have_exp = 1'b1;
		front    = exp_q[d][0];
		due      = due_q[d][0];
		found    = (front == f);
		// popped even on mismatch, one error per bad flit
		void'(exp_q[d].pop_front());
		void'(due_q[d].pop_front());
		outstanding--;
	end else begin
		for (i = 0; i < exp_q[d].size(); i++) begin
			if (!found && exp_q[d][i] == f) begin
				found = 1'b1;
				front = exp_q[d][i];
				due   = due_q[d][i];
				exp_q[d].delete(i);
				due_q[d].delete(i);
				outstanding--;
			end
		end
	end
endtask

`endif

//--- verification/ring_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ring_bus_tb
	import ring_pkg::*;
;
	// cycle budgets per test, the watchdog allows twice their sum
	localparam int RESET_BUDGET = 20;
	localparam int P2P_BUDGET   = NODE_COUNT * NODE_COUNT * 20;
	localparam int ORDER_BUDGET = 60;
	localparam int BP_BUDGET    = 80;
	localparam int CKE_BUDGET   = 80;
	localparam int RAND_CYCLES  = 400;
	localparam int RAND_BUDGET  = RAND_CYCLES + 200;
	localparam int TOTAL_BUDGET = RESET_BUDGET + P2P_BUDGET + ORDER_BUDGET + BP_BUDGET
		+ CKE_BUDGET + RAND_BUDGET;
	localparam realtime CLK_PERIOD = 4.0;

	logic clk   = 1'b0;
	logic reset = 1'b1;
	logic cke   = 1'b0;
	ring_flit_t [NODE_COUNT-1:0] inject_flit;
	logic       [NODE_COUNT-1:0] inject_valid;
	logic       [NODE_COUNT-1:0] eject_ready;
	wire        [NODE_COUNT-1:0] inject_ready;
	wire ring_flit_t [NODE_COUNT-1:0] eject_flit;
	wire        [NODE_COUNT-1:0] eject_valid;

	// test control and counters
	string test_name = "reset_state";
	bit    in_order = 1'b1;
	bit    timing_on = 1'b0;
	bit    idle_check = 1'b0;
	int    cyc = 0;
	int    errors = 0;
	int    tests_run = 0;
	int    tests_failed = 0;
	int    test_start_errors = 0;

	// per-cycle check results, written mid-cycle, sampled at the next edge
	logic       [NODE_COUNT-1:0] chk_take = '0;
	logic       [NODE_COUNT-1:0] chk_match = '0;
	logic       [NODE_COUNT-1:0] chk_have_exp = '0;
	logic       [NODE_COUNT-1:0] chk_dst_ok = '0;
	logic       [NODE_COUNT-1:0] chk_time_ok = '0;
	ring_flit_t [NODE_COUNT-1:0] chk_exp = '0;
	ring_flit_t [NODE_COUNT-1:0] chk_act = '0;
	int         chk_due [NODE_COUNT];
	int         chk_cyc = 0;
	logic       chk_rst_bad = 1'b0;
	logic       chk_hold_bad = 1'b0;
	logic       prev_cke_low = 1'b0;
	logic       [NODE_COUNT-1:0] prev_ev = '0;
	ring_flit_t [NODE_COUNT-1:0] prev_ef = '0;

	`include "ring_bus_scoreboard.svh"

	ring_bus_top dut0 (
		.clk          (clk),
		.reset        (reset),
		.cke          (cke),
		.inject_flit  (inject_flit),
		.inject_valid (inject_valid),
		.inject_ready (inject_ready),
		.eject_flit   (eject_flit),
		.eject_valid  (eject_valid),
		.eject_ready  (eject_ready)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// enabled edges since reset
	always @(posedge clk) begin
		if (!reset && cke) begin
			cyc <= cyc + 1;
		end
	end

	// ------------------------------------------------------------
	// monitor, mid-cycle when outputs are settled
	// ------------------------------------------------------------
	always @(negedge clk) begin
		bit         found;
		bit         have_exp;
		ring_flit_t front;
		int         due;
		chk_rst_bad  = reset && (eject_valid !== '0);
		chk_hold_bad = !cke && prev_cke_low && ((eject_valid !== prev_ev) || (eject_flit !== prev_ef));
		chk_cyc      = cyc;
		for (int d = 0; d < NODE_COUNT; d++) begin
			chk_take[d] = !reset && cke && eject_valid[d] && eject_ready[d];
			chk_match[d]   = 1'b1;
			chk_dst_ok[d]  = 1'b1;
			chk_time_ok[d] = 1'b1;
			if (chk_take[d]) begin
				take_flit(d, eject_flit[d], in_order, found, have_exp, front, due);
				chk_match[d]    = found;
				chk_have_exp[d] = have_exp;
				chk_exp[d]      = front;
				chk_act[d]      = eject_flit[d];
				chk_due[d]      = due;
				chk_dst_ok[d]   = (eject_flit[d].dst == ring_id_t'(d));
				chk_time_ok[d]  = !found || !timing_on || (cyc == due);
			end
		end
		// accepted flits enter the scoreboard
		for (int s = 0; s < NODE_COUNT; s++) begin
			if (!reset && cke && inject_valid[s] && inject_ready[s]) begin
				expect_flit(inject_flit[s], cyc);
			end
		end
		prev_cke_low = !cke;
		prev_ev      = eject_valid;
		prev_ef      = eject_flit;
	end

	// ------------------------------------------------------------
	// assertions
	// ------------------------------------------------------------
	task automatic report_mismatch();
		for (int d = 0; d < NODE_COUNT; d++) begin
			if (chk_take[d] && !chk_match[d]) begin
				errors++;
				if (chk_have_exp[d]) begin
					$display("[ERROR] %s: node %0d flit expected %h actual %h",
						test_name, d, chk_exp[d], chk_act[d]);
				end else begin
					$display("node %0d in test %s ejected a flit that was never injected: %h",
						d, test_name, chk_act[d]);
				end
			end
		end
	endtask

	task automatic report_field(input string what);
		for (int d = 0; d < NODE_COUNT; d++) begin
			if (chk_take[d] && what == "dst" && !chk_dst_ok[d]) begin
				errors++;
				$display("[ERROR] %s: dst expected %0d actual %0d", test_name, d, chk_act[d].dst);
			end
			if (chk_take[d] && what == "time" && !chk_time_ok[d]) begin
				errors++;
				$display("[ERROR] %s: node %0d arrival cycle expected %0d actual %0d",
					test_name, d, chk_due[d], chk_cyc);
			end
		end
	endtask

	a_match: assert property (@(posedge clk) (chk_take & ~chk_match) == '0)
		else report_mismatch();
	a_dst: assert property (@(posedge clk) (chk_take & ~chk_dst_ok) == '0)
		else report_field("dst");
	a_time: assert property (@(posedge clk) (chk_take & ~chk_time_ok) == '0)
		else report_field("time");
	a_reset: assert property (@(posedge clk) !chk_rst_bad)
		else begin
			errors++;
			$display("eject_valid was raised while reset was high");
		end
	a_hold: assert property (@(posedge clk) !chk_hold_bad)
		else begin
			errors++;
			$display("ejection outputs changed in test %s while cke was low", test_name);
		end
	a_idle: assert property (@(posedge clk) idle_check |-> (eject_valid == '0 && inject_ready == '1))
		else begin
			errors++;
			$display("[ERROR] %s: eject_valid/inject_ready expected 0/%h actual %h/%h",
				test_name, {NODE_COUNT{1'b1}}, eject_valid, inject_ready);
		end

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// offer one flit and hold it until the FIFO takes it
	task automatic send_flit(input int s, input int d, input logic [DATA_WIDTH-1:0] p);
		inject_flit[s]  = '{dst: ring_id_t'(d), src: ring_id_t'(s), payload: p};
		inject_valid[s] = 1'b1;
		@(negedge clk);
		while (!(inject_ready[s] && cke)) begin
			@(negedge clk);
		end
		step();
		inject_valid[s] = 1'b0;
	endtask

	// wait until every accepted flit left, then idle to catch duplicates
	task automatic wait_drain();
		while (outstanding != 0) begin
			@(negedge clk);
		end
		repeat (2 * NODE_COUNT + 2) step();
	endtask

	task automatic begin_test(input string name, input bit ordered, input bit timed);
		test_name         = name;
		in_order          = ordered;
		timing_on         = timed;
		test_start_errors = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors != test_start_errors) begin
			tests_failed++;
		end
		$display("test %s finished with %0d errors", test_name, errors - test_start_errors);
	endtask

	// ------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------
	initial begin
		#(TOTAL_BUDGET * 2 * CLK_PERIOD);
		$display("watchdog expired in test %s, %0d flits still outstanding", test_name,
			outstanding);
		$display("tests failed");
		$finish;
	end

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	initial begin
		logic [31:0] r;
		inject_flit  = '0;
		inject_valid = '0;
		eject_ready  = '1;
		cke          = 1'b1;
		reset        = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// reset state
		begin_test("reset_state", 1'b1, 1'b0);
		idle_check = 1'b1;
		repeat (4) step();
		idle_check = 1'b0;
		end_test();

		// every source to every destination, one flit at a time
		begin_test("point_to_point", 1'b1, 1'b1);
		for (int s = 0; s < NODE_COUNT; s++) begin
			for (int d = 0; d < NODE_COUNT; d++) begin
				send_flit(s, d, 16'h1000 + 16'(s * 16 + d));
				wait_drain();
			end
		end
		end_test();

		// back-to-back flits keep their order
		begin_test("ordering", 1'b1, 1'b0);
		for (int i = 0; i < 6; i++) begin
			send_flit(2, 1, 16'h2000 + 16'(i));
		end
		wait_drain();
		end_test();

		// refused flit keeps circulating until ready rises
		begin_test("eject_backpressure", 1'b1, 1'b0);
		eject_ready[3] = 1'b0;
		send_flit(0, 3, 16'h3bad);
		repeat (3 * NODE_COUNT) step();
		eject_ready[3] = 1'b1;
		wait_drain();
		end_test();

		// freeze mid-flight, offers during the freeze must not be taken
		begin_test("clock_enable", 1'b1, 1'b0);
		for (int i = 0; i < 4; i++) begin
			send_flit(1, 3, 16'h4000 + 16'(i));
		end
		cke             = 1'b0;
		inject_flit[0]  = '{dst: ring_id_t'(2), src: ring_id_t'(0), payload: 16'h4fff};
		inject_valid[0] = 1'b1;
		repeat (10) step();
		cke             = 1'b1;
		inject_valid[0] = 1'b0;
		wait_drain();
		end_test();

		// random traffic on all nodes
		begin_test("random_traffic", 1'b0, 1'b0);
		for (int c = 0; c < RAND_CYCLES; c++) begin
			next_rand(r);
			inject_valid = r[NODE_COUNT-1:0];
			eject_ready  = r[2*NODE_COUNT-1:NODE_COUNT];
			for (int s = 0; s < NODE_COUNT; s++) begin
				next_rand(r);
				inject_flit[s] = '{dst: r[ID_WIDTH-1:0], src: ring_id_t'(s), payload: r[31:16]};
			end
			step();
		end
		inject_valid = '0;
		eject_ready  = '1;
		wait_drain();
		end_test();

		$display("tests run %0d, failing %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/ring_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------
// ring bus top
// NODE_COUNT nodes chained in one direction,
// last link closes back to node 0
// ------------------------------------------------------------
module ring_bus_top
	import ring_pkg::*;
(
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              cke,

	// producer ports, one per node
	input  wire ring_flit_t [NODE_COUNT-1:0] inject_flit,
	input  wire             [NODE_COUNT-1:0] inject_valid,
	output wire             [NODE_COUNT-1:0] inject_ready,

	// consumer ports, one per node
	output wire ring_flit_t [NODE_COUNT-1:0] eject_flit,
	output wire             [NODE_COUNT-1:0] eject_valid,
	input  wire             [NODE_COUNT-1:0] eject_ready
);

	// ------------------------------------------------------------
	// ring links
	// ------------------------------------------------------------

	// link k is driven by node k and read by node k+1
	ring_flit_t [NODE_COUNT-1:0] link_flit;
	logic       [NODE_COUNT-1:0] link_valid;

	// ------------------------------------------------------------
	// nodes
	// ------------------------------------------------------------

	genvar k;

	generate
		for (k = 0; k < NODE_COUNT; k++) begin : g_node
			// upstream neighbour, node 0 wraps to the last one
			localparam int PREV = (k + NODE_COUNT - 1) % NODE_COUNT;

			ring_node #(
				.NODE_ID (ring_id_t'(k))
			) u_node (
				.clk          (clk),
				.reset        (reset),
				.cke          (cke),
				.inject_flit  (inject_flit[k]),
				.inject_valid (inject_valid[k]),
				.inject_ready (inject_ready[k]),
				.in_flit      (link_flit[PREV]),
				.in_valid     (link_valid[PREV]),
				.eject_flit   (eject_flit[k]),
				.eject_valid  (eject_valid[k]),
				.eject_ready  (eject_ready[k]),
				.out_flit     (link_flit[k]),
				.out_valid    (link_valid[k])
			);
		end
	endgenerate

endmodule

`default_nettype wire

//--- ring/ring_node.sv
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------
// ring node
// one injection queue feeding one ring stop,
// the unit that the top replicates around the ring
// ------------------------------------------------------------
module ring_node
	import ring_pkg::*;
#(
	parameter ring_id_t NODE_ID = '0
) (
	input  wire             clk,
	input  wire             reset,
	input  wire             cke,

	// producer port
	input  wire ring_flit_t inject_flit,
	input  wire             inject_valid,
	output wire             inject_ready,

	// ring link in
	input  wire ring_flit_t in_flit,
	input  wire             in_valid,

	// consumer port
	output wire ring_flit_t eject_flit,
	output wire             eject_valid,
	input  wire             eject_ready,

	// ring link out
	output wire ring_flit_t out_flit,
	output wire             out_valid
);

	// queue head handshake
	ring_flit_t head_flit;
	logic       head_valid;
	logic       head_ready;

	// buffer between producer and stop
	inject_fifo u_fifo (
		.clk       (clk),
		.reset     (reset),
		.cke       (cke),
		.in_flit   (inject_flit),
		.in_valid  (inject_valid),
		.in_ready  (inject_ready),
		.out_flit  (head_flit),
		.out_valid (head_valid),
		.out_ready (head_ready)
	);

	// station on the ring, carries this node's id
	ring_stop #(
		.UNIT_ID (NODE_ID)
	) u_stop (
		.clk         (clk),
		.reset       (reset),
		.cke         (cke),
		.in_flit     (in_flit),
		.in_valid    (in_valid),
		.head_flit   (head_flit),
		.head_valid  (head_valid),
		.head_ready  (head_ready),
		.eject_flit  (eject_flit),
		.eject_valid (eject_valid),
		.eject_ready (eject_ready),
		.out_flit    (out_flit),
		.out_valid   (out_valid)
	);

endmodule

`default_nettype wire

//--- ring/ring_stop.sv
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------
// ring stop
// forwards the ring slot by one hop per enabled clock,
// offers matching flits for ejection and inserts the
// queue head into an empty or freed slot
// ------------------------------------------------------------
module ring_stop
	import ring_pkg::*;
#(
	parameter ring_id_t UNIT_ID = '0
) (
	input  wire             clk,
	input  wire             reset,
	input  wire             cke,

	// incoming ring link
	input  wire ring_flit_t in_flit,
	input  wire             in_valid,

	// head of the injection queue
	input  wire ring_flit_t head_flit,
	input  wire             head_valid,
	output logic            head_ready,

	// ejection port
	output ring_flit_t      eject_flit,
	output logic            eject_valid,
	input  wire             eject_ready,

	// registered outgoing ring link
	output ring_flit_t      out_flit,
	output logic            out_valid
);

	// slot handshakes for this cycle
	logic eject_take;
	logic insert;

	// ------------------------------------------------------------
	// ejection
	// ------------------------------------------------------------

	// flit is offered when it is addressed to this stop
	assign eject_valid = in_valid && (in_flit.dst == UNIT_ID);

	// payload goes straight through in the same cycle
	assign eject_flit = in_flit;

	// consumer takes it this cycle
	assign eject_take = eject_valid && eject_ready;

	// ------------------------------------------------------------
	// insertion
	// ------------------------------------------------------------

	// slot is free if empty or if its flit leaves right here
	assign head_ready = !in_valid || eject_take;

	// queue head goes into the slot
	assign insert = head_valid && head_ready;

	// ------------------------------------------------------------
	// outgoing link register
	// ------------------------------------------------------------

	// insertion wins over ejection for the valid strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (cke) begin
			if (insert) begin
				out_valid <= 1'b1;
			end else if (eject_take) begin
				// slot freed and nothing to put in
				out_valid <= 1'b0;
			end else begin
				// plain forward of the incoming slot
				// refused flits for us go round again
				out_valid <= in_valid;
			end
		end
	end

	// flit contents follow the same priority
	always_ff @(posedge clk) begin
		if (cke) begin
			if (insert) begin
				out_flit <= head_flit;
			end else begin
				// after an ejection this copy sits behind a low valid
				out_flit <= in_flit;
			end
		end
	end

endmodule

`default_nettype wire

//--- ring/inject_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// ------------------------------------------------------------
// injection queue
// circular buffer in front of a ring stop,
// valid/ready on both sides
// ------------------------------------------------------------
module inject_fifo
	import ring_pkg::*;
(
	input  wire             clk,
	input  wire             reset,
	input  wire             cke,

	// producer side
	input  wire ring_flit_t in_flit,
	input  wire             in_valid,
	output logic            in_ready,

	// ring stop side
	output ring_flit_t      out_flit,
	output logic            out_valid,
	input  wire             out_ready
);

	// storage
	ring_flit_t mem [FIFO_DEPTH];

	// pointers and fill level
	logic [PTR_WIDTH-1:0]   wr_ptr;
	logic [PTR_WIDTH-1:0]   rd_ptr;
	logic [COUNT_WIDTH-1:0] count;

	// status and handshakes
	logic full;
	logic push;
	logic pop;

	// ------------------------------------------------------------
	// status
	// ------------------------------------------------------------

	assign full = (count == COUNT_WIDTH'(FIFO_DEPTH));

	// accept when there is room, or when full but the head leaves now
	assign in_ready = !full || out_ready;

	// head valid one cycle after the first write
	assign out_valid = (count != '0);
	assign out_flit  = mem[rd_ptr];

	// transfers only count with the clock enable
	assign push = cke && in_valid && in_ready;
	assign pop  = cke && out_valid && out_ready;

	// ------------------------------------------------------------
	// pointers and count
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// write pointer, wraps at the last entry
			if (push) begin
				if (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end

			// read pointer
			if (pop) begin
				if (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end

			// fill level, unchanged on push and pop together
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// storage write
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_flit;
		end
	end

endmodule

`default_nettype wire

//--- common/ring_pkg.sv
`default_nettype none

// ------------------------------------------------------------
// ring bus shared sizes and flit format
// ------------------------------------------------------------
package ring_pkg;

	// number of stops on the ring
	localparam int NODE_COUNT = 4;

	// stop id width, enough to address every stop
	localparam int ID_WIDTH = 2;

	// flit payload width
	localparam int DATA_WIDTH = 16;

	// entries per injection queue
	localparam int FIFO_DEPTH = 4;

	// queue pointer width
	localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

	// occupancy counter width, must reach FIFO_DEPTH itself
	localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	// ------------------------------------------------------------
	// types
	// ------------------------------------------------------------

	// stop id
	typedef logic [ID_WIDTH-1:0] ring_id_t;

	// one flit on the ring
	// dst picks the ejecting stop
	// src is carried along untouched
	typedef struct packed {
		ring_id_t              dst;
		ring_id_t              src;
		logic [DATA_WIDTH-1:0] payload;
	} ring_flit_t;

endpackage

`default_nettype wire
